/* src.f */
+incdir+.
sort_pkg.sv
elem_gen.sv
elem_fifo.sv
sort4_unit.sv
sort_top.sv
tb_clock.sv
sort_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the sort testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module sort_tb -o sort_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sort_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

/* sort_tb.sv */
`default_nettype none

`include "sort_consts.svh"

module sort_tb import sort_pkg::*; ();

  localparam int NTEST     = 8;
  localparam int RST_CYCLES = 10;

  localparam logic [1:0] HOLD_NONE   = 2'd0;
  localparam logic [1:0] HOLD_EVERY3 = 2'd1;
  localparam logic [1:0] HOLD_RANDOM = 2'd2;

  // ########################################
  // stimulus table
  // ########################################

  // row is {mode[83:82], seed[81:18], count[17:2], hold[1:0]}
  logic [83:0] tbl [NTEST] = '{
    {`MODE_XORSHIFT, 64'd58,                  16'd12, HOLD_NONE},
    {`MODE_XORSHIFT, 64'd0,                   16'd10, HOLD_EVERY3},
    {`MODE_REVERSE,  64'd0,                   16'd16, HOLD_NONE},
    {`MODE_SORTED,   64'd0,                   16'd16, HOLD_NONE},
    {`MODE_XORSHIFT, 64'h0123_4567_89ab_cdef, 16'd40, HOLD_RANDOM},
    {`MODE_REVERSE,  64'd0,                   16'd40, HOLD_EVERY3},
    {`MODE_SORTED,   64'd0,                   16'd1,  HOLD_NONE},
    {`MODE_XORSHIFT, 64'd58,                  16'd1,  HOLD_RANDOM}
  };

  logic                   CLK;
  logic                   RSTa;
  logic                   i_start;
  init_mode_t             i_mode;
  logic [`SORT_WORDW-1:0] i_seed;
  logic [15:0]            i_count;
  logic                   i_hold;
  logic                   o_valid;
  sort_word_t             o_word;
  logic                   o_done;

  integer rnd_seed = 58;
  int     err_cnt  = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;

  // expected words of the running block
  logic [`SORT_WORDW-1:0] exp_q [$];

  tb_clock #(.PERIOD(100)) clk_i (.o_clk(CLK));

  sort_top dut_i (
    .CLK     (CLK),
    .RSTa    (RSTa),
    .i_start (i_start),
    .i_mode  (i_mode),
    .i_seed  (i_seed),
    .i_count (i_count),
    .i_hold  (i_hold),
    .o_valid (o_valid),
    .o_word  (o_word),
    .o_done  (o_done)
  );

  // ########################################
  // reference model
  // ########################################
  function automatic logic [63:0] xorshift_step(input logic [63:0] x);
    logic [63:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 7);
    r = r ^ (r << 17);
    return r;
  endfunction

  // plain bubble sort leaving key 0 smallest
  function automatic logic [63:0] sort_keys(input logic [63:0] w);
    logic [15:0] k [`SORT_WAY];
    logic [15:0] tmp;
    logic [63:0] r;
    for (int i = 0; i < `SORT_WAY; i++) k[i] = w[`SORT_KEYW*i +: `SORT_KEYW];
    for (int p = 0; p < `SORT_WAY - 1; p++) begin
      for (int i = 0; i < `SORT_WAY - 1 - p; i++) begin
        if (k[i] > k[i+1]) begin
          tmp    = k[i];
          k[i]   = k[i+1];
          k[i+1] = tmp;
        end
      end
    end
    for (int i = 0; i < `SORT_WAY; i++) r[`SORT_KEYW*i +: `SORT_KEYW] = k[i];
    return r;
  endfunction

  task automatic build_expected(input logic [1:0] mode, input logic [63:0] seed, input int n);
    logic [63:0] x;
    logic [63:0] w;
    exp_q.delete();
    x = (seed == 64'd0) ? 64'd1 : seed;
    for (int k = 0; k < n; k++) begin
      case (mode)
        `MODE_XORSHIFT: begin
          x = xorshift_step(x);
          w = x;
        end
        `MODE_REVERSE: begin
          for (int j = 0; j < `SORT_WAY; j++) w[16*j +: 16] = 16'(4*n - 4*k - j);
        end
        default: begin
          for (int j = 0; j < `SORT_WAY; j++) w[16*j +: 16] = 16'(4*k + j + 1);
        end
      endcase
      // sorted blocks must come out exactly as generated
      if (mode != `MODE_SORTED) w = sort_keys(w);
      exp_q.push_back(w);
    end
  endtask

  // ########################################
  // checking
  // ########################################
  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got_v);
    if (got_v !== exp_v) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
      err_cnt++;
    end
  endtask

  task automatic run_test(input int t);
    logic [1:0]  mode;
    logic [63:0] seed;
    logic [1:0]  hold_sel;
    int          n;
    int          got;
    int          drain;
    int          cyc;
    int          limit;
    int          err0;
    int          r;
    logic        hold_nxt;
    mode     = tbl[t][83:82];
    seed     = tbl[t][81:18];
    n        = int'(tbl[t][17:2]);
    hold_sel = tbl[t][1:0];
    limit    = n * 20 + 50;
    err0     = err_cnt;
    build_expected(mode, seed, n);
    @(posedge CLK);
    if (t > 0) check_value("o_done before start", 64'd1, 64'(o_done));
    i_start <= 1'b1;
    i_mode  <= init_mode_t'(mode);
    i_seed  <= seed;
    i_count <= 16'(n);
    got   = 0;
    drain = 0;
    cyc   = 0;
    while (drain < 3 && cyc < limit) begin
      @(posedge CLK);
      i_start <= 1'b0;
      case (hold_sel)
        HOLD_EVERY3: hold_nxt = (cyc % 3 == 2);
        HOLD_RANDOM: begin
          r        = $random(rnd_seed);
          hold_nxt = r[0];
        end
        default: hold_nxt = 1'b0;
      endcase
      i_hold <= hold_nxt;
      @(negedge CLK);
      // done only after the last word has left
      check_value("o_done", 64'(got == n), 64'(o_done));
      if (o_valid && i_hold) begin
        $display("test %0d: o_valid high while i_hold high at %0t", t, $time);
        err_cnt++;
      end
      if (o_valid) begin
        if (got < n) begin
          check_value($sformatf("o_word[%0d]", got), exp_q[got], o_word.raw);
        end else begin
          $display("test %0d: extra word %h after the block at %0t", t, o_word.raw, $time);
          err_cnt++;
        end
        got++;
      end
      if (got >= n) drain++;
      cyc++;
    end
    if (drain < 3) begin
      $display("test %0d: block not finished after %0d cycles, %0d of %0d words seen",
               t, limit, got, n);
      err_cnt++;
    end
    @(posedge CLK);
    i_hold <= 1'b0;
    if (err_cnt == err0) begin
      pass_cnt++;
      $display("test %0d ok: mode %0d, %0d words", t, mode, n);
    end else begin
      fail_cnt++;
      $display("test %0d failed: mode %0d, %0d words, %0d errors", t, mode, n, err_cnt - err0);
    end
  endtask

  // ########################################
  // main sequence
  // ########################################
  initial begin
    RSTa    = 1'b1;
    i_start = 1'b0;
    i_mode  = INIT_XORSHIFT;
    i_seed  = '0;
    i_count = '0;
    i_hold  = 1'b0;
    repeat (RST_CYCLES - 1) begin
      @(posedge CLK);
      @(negedge CLK);
      check_value("o_valid in reset", 64'd0, 64'(o_valid));
      check_value("o_done in reset", 64'd0, 64'(o_done));
    end
    @(posedge CLK);
    RSTa <= 1'b0;
    // idle before the first start
    repeat (3) begin
      @(negedge CLK);
      check_value("o_valid idle", 64'd0, 64'(o_valid));
      check_value("o_done idle", 64'd0, 64'(o_done));
    end
    for (int t = 0; t < NTEST; t++) run_test(t);
    $display("tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    int total;
    int limit;
    total = 0;
    for (int i = 0; i < NTEST; i++) total += int'(tbl[i][17:2]);
    limit = total * 20 + 200;
    repeat (limit) @(posedge CLK);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // free running, toggles every half period
  always begin
    #(PERIOD / 2);
    o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

/* sort_top.sv */
`default_nettype none

`include "sort_consts.svh"

module sort_top import sort_pkg::*; (
  input  logic                   CLK,
  input  logic                   RSTa,
  input  logic                   i_start,
  input  init_mode_t             i_mode,
  input  logic [`SORT_WORDW-1:0] i_seed,
  input  logic [15:0]            i_count,
  input  logic                   i_hold,
  output logic                   o_valid,
  output sort_word_t             o_word,
  output logic                   o_done
);

  // producer to buffer
  logic       wr_en;
  sort_word_t wr_word;
  logic       wr_last;
  logic       fifo_full;

  // buffer to consumer
  sort_word_t rd_word;
  logic       rd_last;
  logic       not_empty;
  logic       rd_en;

  // ########################################
  // producer
  // ########################################
  elem_gen gen_i (
    .CLK         (CLK),
    .RSTa        (RSTa),
    .i_start     (i_start),
    .i_mode      (i_mode),
    .i_seed      (i_seed),
    .i_count     (i_count),
    .i_fifo_full (fifo_full),
    .o_wr_en     (wr_en),
    .o_wr_word   (wr_word),
    .o_wr_last   (wr_last)
  );

  // ########################################
  // buffer
  // ########################################
  elem_fifo #(
    .DEPTH_LOG (`FIFO_DEPTH_LOG)
  ) fifo_i (
    .CLK         (CLK),
    .RSTa        (RSTa),
    .i_wr_en     (wr_en),
    .i_wr_word   (wr_word),
    .i_wr_last   (wr_last),
    .i_rd_en     (rd_en),
    .o_rd_word   (rd_word),
    .o_rd_last   (rd_last),
    .o_full      (fifo_full),
    .o_not_empty (not_empty)
  );

  // ########################################
  // consumer
  // ########################################
  sort4_unit sort_i (
    .CLK         (CLK),
    .RSTa        (RSTa),
    .i_not_empty (not_empty),
    .i_word      (rd_word),
    .i_last      (rd_last),
    .i_hold      (i_hold),
    .i_start     (i_start),
    .o_rd_en     (rd_en),
    .o_valid     (o_valid),
    .o_word      (o_word),
    .o_done      (o_done)
  );

endmodule

`default_nettype wire

/* sort4_unit.sv */
`default_nettype none

`include "sort_consts.svh"

module sort4_unit import sort_pkg::*; (
  input  logic       CLK,
  input  logic       RSTa,
  input  logic       i_not_empty,
  input  sort_word_t i_word,
  input  logic       i_last,
  input  logic       i_hold,
  input  logic       i_start,
  output logic       o_rd_en,
  output logic       o_valid,
  output sort_word_t o_word,
  output logic       o_done
);

  // swap keys lo and hi when out of order
  function automatic sort_word_t cex(input sort_word_t w, input int lo, input int hi);
    sort_word_t r;
    r = w;
    if (w.keys[lo] > w.keys[hi]) begin
      r.keys[lo] = w.keys[hi];
      r.keys[hi] = w.keys[lo];
    end
    return r;
  endfunction

  // stage registers
  sort_word_t s1_word;
  sort_word_t s2_word;
  sort_word_t s3_word;
  logic       s1_vld;
  logic       s2_vld;
  logic       s3_vld;
  logic       s1_last;
  logic       s2_last;
  logic       s3_last;

  // network inputs to each stage
  sort_word_t st1_word;
  sort_word_t st2_word;
  sort_word_t st3_word;

  // words inside the network, 0 to 3
  logic [1:0] flight_cnt;
  logic       done_q;

  // pop only when the pipe moves
  assign o_rd_en = i_not_empty && !i_hold;

  // ########################################
  // compare-exchange network
  // ########################################

  // pairs 0/1 and 2/3
  assign st1_word = cex(cex(i_word, 0, 1), 2, 3);
  // pairs 0/2 and 1/3
  assign st2_word = cex(cex(s1_word, 0, 2), 1, 3);
  // middle pair 1/2
  assign st3_word = cex(s2_word, 1, 2);

  always_ff @(posedge CLK) begin
    if (!i_hold) begin
      s1_word <= st1_word;
      s2_word <= st2_word;
      s3_word <= st3_word;
    end
  end

  // ########################################
  // valid and last tags
  // ########################################
  always_ff @(posedge CLK) begin
    if (RSTa) begin
      s1_vld  <= 1'b0;
      s2_vld  <= 1'b0;
      s3_vld  <= 1'b0;
      s1_last <= 1'b0;
      s2_last <= 1'b0;
      s3_last <= 1'b0;
    end else if (!i_hold) begin
      s1_vld  <= o_rd_en;
      s1_last <= o_rd_en && i_last;
      s2_vld  <= s1_vld;
      s2_last <= s1_last;
      s3_vld  <= s2_vld;
      s3_last <= s2_last;
    end
  end

  // stage 3 retires on the edge where hold is low
  assign o_valid = s3_vld && !i_hold;
  assign o_word  = s3_word;

  // ########################################
  // word count in flight
  // ########################################
  always_ff @(posedge CLK) begin
    if (RSTa) begin
      flight_cnt <= '0;
    end else begin
      case ({o_rd_en, o_valid})
        2'b10:   flight_cnt <= flight_cnt + 2'd1;
        2'b01:   flight_cnt <= flight_cnt - 2'd1;
        default: flight_cnt <= flight_cnt;
      endcase
    end
  end

  // ########################################
  // done flag
  // ########################################

  // last word out with nothing behind it
  always_ff @(posedge CLK) begin
    if (RSTa) begin
      done_q <= 1'b0;
    end else begin
      if (i_start) begin
        done_q <= 1'b0;
      end else if (o_valid && s3_last && flight_cnt == 2'd1) begin
        done_q <= 1'b1;
      end
    end
  end

  assign o_done = done_q;

endmodule

`default_nettype wire

/* elem_fifo.sv */
`default_nettype none

`include "sort_consts.svh"

module elem_fifo import sort_pkg::*; #(
  parameter int DEPTH_LOG = `FIFO_DEPTH_LOG
) (
  input  logic       CLK,
  input  logic       RSTa,
  input  logic       i_wr_en,
  input  sort_word_t i_wr_word,
  input  logic       i_wr_last,
  input  logic       i_rd_en,
  output sort_word_t o_rd_word,
  output logic       o_rd_last,
  output logic       o_full,
  output logic       o_not_empty
);

  localparam int DEPTH = 1 << DEPTH_LOG;

  // entry is {last, word}
  logic [`SORT_WORDW:0] mem [DEPTH];
  logic [`SORT_WORDW:0] head;

  // one extra wrap bit on each pointer
  logic [DEPTH_LOG:0] wr_ptr;
  logic [DEPTH_LOG:0] rd_ptr;

  // ########################################
  // levels
  // ########################################
  assign o_not_empty = (wr_ptr != rd_ptr);
  assign o_full      = (wr_ptr[DEPTH_LOG] != rd_ptr[DEPTH_LOG]) &&
                       (wr_ptr[DEPTH_LOG-1:0] == rd_ptr[DEPTH_LOG-1:0]);

  // ########################################
  // storage
  // ########################################
  always_ff @(posedge CLK) begin
    if (i_wr_en) mem[wr_ptr[DEPTH_LOG-1:0]] <= {i_wr_last, i_wr_word};
  end

  // head word shown without a read cycle
  assign head      = mem[rd_ptr[DEPTH_LOG-1:0]];
  assign o_rd_last = head[`SORT_WORDW];
  assign o_rd_word = head[`SORT_WORDW-1:0];

  // ########################################
  // pointers
  // ########################################
  always_ff @(posedge CLK) begin
    if (RSTa) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (i_rd_en) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* elem_gen.sv */
`default_nettype none

`include "sort_consts.svh"

module elem_gen import sort_pkg::*; (
  input  logic                   CLK,
  input  logic                   RSTa,
  input  logic                   i_start,
  input  init_mode_t             i_mode,
  input  logic [`SORT_WORDW-1:0] i_seed,
  input  logic [15:0]            i_count,
  input  logic                   i_fifo_full,
  output logic                   o_wr_en,
  output sort_word_t             o_wr_word,
  output logic                   o_wr_last
);

  // block control
  logic        active;
  logic [15:0] remain;
  init_mode_t  mode_q;

  // per-mode generator state
  logic [`SORT_WORDW-1:0] xs_state;
  logic [`SORT_KEYW-1:0]  rev_base;
  logic [`SORT_KEYW-1:0]  asc_base;

  // xorshift64 step, shifts 13 / 7 / 17
  logic [`SORT_WORDW-1:0] xs_a;
  logic [`SORT_WORDW-1:0] xs_b;
  logic [`SORT_WORDW-1:0] xs_next;

  assign xs_a    = xs_state ^ (xs_state << 13);
  assign xs_b    = xs_a ^ (xs_a >> 7);
  assign xs_next = xs_b ^ (xs_b << 17);

  // write only while the buffer has room
  assign o_wr_en   = active && !i_fifo_full;
  assign o_wr_last = (remain == 16'd1);

  // ########################################
  // word formation
  // ########################################
  always_comb begin
    o_wr_word.raw = '0;
    case (mode_q)
      INIT_REVERSE: begin
        // descending, key j = base - j
        for (int j = 0; j < `SORT_WAY; j++) begin
          o_wr_word.keys[j] = rev_base - `SORT_KEYW'(j);
        end
      end
      INIT_SORTED: begin
        // ascending, key j = base + j + 1
        for (int j = 0; j < `SORT_WAY; j++) begin
          o_wr_word.keys[j] = asc_base + `SORT_KEYW'(j + 1);
        end
      end
      default: begin
        // first word is one step past the seed
        o_wr_word.raw = xs_next;
      end
    endcase
  end

  // ########################################
  // block control
  // ########################################
  always_ff @(posedge CLK) begin
    if (RSTa) begin
      active <= 1'b0;
      remain <= '0;
      mode_q <= INIT_XORSHIFT;
    end else begin
      if (i_start) begin
        active <= (i_count != 16'd0);
        remain <= i_count;
        mode_q <= i_mode;
      end else if (o_wr_en) begin
        remain <= remain - 16'd1;
        if (remain == 16'd1) active <= 1'b0;
      end
    end
  end

  // ########################################
  // generator state
  // ########################################
  always_ff @(posedge CLK) begin
    if (i_start) begin
      // zero would lock xorshift at zero
      xs_state <= (i_seed == '0) ? `SORT_WORDW'(1) : i_seed;
      rev_base <= `SORT_KEYW'({i_count[13:0], 2'b00});
      asc_base <= '0;
    end else if (o_wr_en) begin
      case (mode_q)
        INIT_REVERSE: rev_base <= rev_base - `SORT_KEYW'(`SORT_WAY);
        INIT_SORTED:  asc_base <= asc_base + `SORT_KEYW'(`SORT_WAY);
        default:      xs_state <= xs_next;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sort_pkg.sv */
`default_nettype none

`include "sort_consts.svh"

package sort_pkg;

  // ########################################
  // sort word
  // ########################################

  // raw view is written by the xorshift generator,
  // key view is used by the network and the counting generators
  // key 0 sits in the least significant bits
  typedef union packed {
    logic [`SORT_WORDW-1:0]                raw;
    logic [`SORT_WAY-1:0][`SORT_KEYW-1:0]  keys;
  } sort_word_t;

  // ########################################
  // generation modes
  // ########################################
  typedef enum logic [1:0] {
    INIT_XORSHIFT = `MODE_XORSHIFT,
    INIT_REVERSE  = `MODE_REVERSE,
    INIT_SORTED   = `MODE_SORTED
  } init_mode_t;

endpackage

`default_nettype wire

/* sort_consts.svh */
`ifndef SORT_CONSTS_SVH
`define SORT_CONSTS_SVH

// ########################################
// key and word geometry
// ########################################

// width of one key
`define SORT_KEYW       16
// keys packed in one word
`define SORT_WAY        4
// word width, SORT_KEYW * SORT_WAY
`define SORT_WORDW      64

// ########################################
// buffering
// ########################################

// log2 of fifo depth, 8 words
`define FIFO_DEPTH_LOG  3

// ########################################
// generation mode codes
// ########################################
`define MODE_XORSHIFT   2'd0
`define MODE_REVERSE    2'd1
`define MODE_SORTED     2'd2

`endif
